// File: verilog/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Response FIFO entries, and so the number of responses in flight.
`define ALU_FIFO_DEPTH 4

// Bit positions inside the Z80 flag byte.
`define FLAG_S 7
`define FLAG_Z 6
`define FLAG_5 5  // Undocumented, copied from F.
`define FLAG_H 4
`define FLAG_3 3  // Undocumented, copied from F.
`define FLAG_V 2
`define FLAG_N 1
`define FLAG_C 0

`endif

// File: verilog/alu_pkg.sv
package alu_pkg;

  typedef logic [7:0]  byte_t;   // 8-bit operand or result.
  typedef logic [15:0] word_t;   // 16-bit operand or result.
  typedef logic [7:0]  flags_t;  // S Z 5 H 3 V N C from bit 7 down to bit 0.

  // Z80 ALU function codes, in the order of the opcode group.
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_ADC = 4'd1,
    ALU_SUB = 4'd2,
    ALU_SBC = 4'd3,
    ALU_AND = 4'd4,
    ALU_XOR = 4'd5,
    ALU_OR  = 4'd6,
    ALU_CP  = 4'd7
  } alu_func_t;

  // An 8-bit request uses the low byte of x and y.
  typedef struct packed {
    alu_func_t func;
    logic      wide;  // Set for a 16-bit operation.
    word_t     x;
    word_t     y;
  } alu_req_t;

  typedef struct packed {
    word_t  result;   // Zero-extended for 8-bit requests.
    flags_t flags;
    logic   illegal;  // 16-bit logic request.
    logic   wb;       // Result should be written back.
  } alu_rsp_t;

endpackage

// File: verilog/alu8.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu8 (
  input  alu_pkg::byte_t     x,
  input  alu_pkg::byte_t     y,
  input  alu_pkg::alu_func_t func,
  input  alu_pkg::flags_t    f_in,
  output alu_pkg::byte_t     out,
  output alu_pkg::flags_t    f
);

  logic           sub_op;
  logic           logic_op;
  logic           cin;
  alu_pkg::byte_t y_op;
  logic [8:0]     sum;
  alu_pkg::byte_t logic_res;

  always_comb begin
    sub_op = 1'b0;
    cin    = 1'b0;
    case (func)
      alu_pkg::ALU_ADC: cin = f_in[`FLAG_C];
      alu_pkg::ALU_SUB, alu_pkg::ALU_CP: begin
        sub_op = 1'b1;
        cin    = 1'b1;  // Two's complement of y.
      end
      alu_pkg::ALU_SBC: begin
        sub_op = 1'b1;
        cin    = ~f_in[`FLAG_C];  // A pending borrow removes the +1.
      end
      default: ;
    endcase
  end

  assign y_op = sub_op ? ~y : y;
  assign sum  = {1'b0, x} + {1'b0, y_op} + {8'h00, cin};

  assign logic_op = (func == alu_pkg::ALU_AND) || (func == alu_pkg::ALU_XOR) ||
                    (func == alu_pkg::ALU_OR);

  always_comb begin
    case (func)
      alu_pkg::ALU_AND: logic_res = x & y;
      alu_pkg::ALU_XOR: logic_res = x ^ y;
      default:          logic_res = x | y;
    endcase
  end

  always_comb begin
    f = f_in;  // Keeps bits 5 and 3.
    if (logic_op) begin
      out        = logic_res;
      f[`FLAG_H] = (func == alu_pkg::ALU_AND);
      f[`FLAG_V] = ~^logic_res;  // Set on even parity.
      f[`FLAG_N] = 1'b0;
      f[`FLAG_C] = 1'b0;
    end else begin
      out        = sum[7:0];
      f[`FLAG_H] = x[4] ^ y[4] ^ sum[4];  // Carry or borrow out of bit 3.
      f[`FLAG_V] = (x[7] == y_op[7]) && (sum[7] != x[7]);
      f[`FLAG_N] = sub_op;
      f[`FLAG_C] = sum[8] ^ sub_op;  // Borrow for subtraction.
    end
    f[`FLAG_S] = out[7];
    f[`FLAG_Z] = (out == 8'h00);
  end

endmodule

// File: verilog/alu16.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu16 (
  input  alu_pkg::word_t     x,
  input  alu_pkg::word_t     y,
  input  alu_pkg::alu_func_t func,
  input  alu_pkg::flags_t    f_in,
  output alu_pkg::word_t     out,
  output alu_pkg::flags_t    f
);

  logic           sub_op;
  logic           cin;
  alu_pkg::word_t y_op;
  logic [16:0]    sum;

  // Only the add and subtract group is decoded here.
  always_comb begin
    sub_op = 1'b0;
    cin    = 1'b0;
    case (func)
      alu_pkg::ALU_ADC: cin = f_in[`FLAG_C];
      alu_pkg::ALU_SUB, alu_pkg::ALU_CP: begin
        sub_op = 1'b1;
        cin    = 1'b1;
      end
      alu_pkg::ALU_SBC: begin
        sub_op = 1'b1;
        cin    = ~f_in[`FLAG_C];
      end
      default: ;
    endcase
  end

  assign y_op = sub_op ? ~y : y;
  assign sum  = {1'b0, x} + {1'b0, y_op} + {16'h0000, cin};
  assign out  = sum[15:0];

  always_comb begin
    f          = f_in;
    f[`FLAG_S] = sum[15];
    f[`FLAG_Z] = (sum[15:0] == 16'h0000);
    f[`FLAG_H] = x[12] ^ y[12] ^ sum[12];  // Carry or borrow out of bit 11.
    f[`FLAG_V] = (x[15] == y_op[15]) && (sum[15] != x[15]);
    f[`FLAG_N] = sub_op;
    f[`FLAG_C] = sum[16] ^ sub_op;
  end

endmodule

// File: verilog/alu_exec.sv
`timescale 1ns/10ps

module alu_exec (
  input  logic              clk,
  input  logic              arst_n,
  input  alu_pkg::alu_req_t req,
  input  logic              accept,
  output alu_pkg::alu_rsp_t rsp
);

  alu_pkg::flags_t f_q;  // The F register.
  alu_pkg::byte_t  out8;
  alu_pkg::flags_t f8;
  alu_pkg::word_t  out16;
  alu_pkg::flags_t f16;
  logic            illegal;

  alu8 u_alu8 (
    .x    (req.x[7:0]),
    .y    (req.y[7:0]),
    .func (req.func),
    .f_in (f_q),
    .out  (out8),
    .f    (f8)
  );

  alu16 u_alu16 (
    .x    (req.x),
    .y    (req.y),
    .func (req.func),
    .f_in (f_q),
    .out  (out16),
    .f    (f16)
  );

  always_comb begin
    case (req.func)
      alu_pkg::ALU_ADD, alu_pkg::ALU_ADC, alu_pkg::ALU_SUB,
      alu_pkg::ALU_SBC, alu_pkg::ALU_CP: illegal = 1'b0;
      alu_pkg::ALU_AND, alu_pkg::ALU_XOR,
      alu_pkg::ALU_OR:                   illegal = req.wide;  // No 16-bit logic ops.
      default:                           illegal = 1'b1;
    endcase
  end

  always_comb begin
    rsp.illegal = illegal;
    rsp.wb      = !illegal && (req.func != alu_pkg::ALU_CP);  // CP only sets flags.
    if (illegal) begin
      rsp.result = '0;
      rsp.flags  = f_q;
    end else if (req.wide) begin
      rsp.result = out16;
      rsp.flags  = f16;
    end else begin
      rsp.result = {8'h00, out8};
      rsp.flags  = f8;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      f_q <= '0;
    end else if (accept && !illegal) begin
      f_q <= rsp.flags;
    end
  end

endmodule

// File: verilog/result_fifo.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module result_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  alu_pkg::alu_rsp_t push_data,
  input  logic              push,
  output logic              full,
  output alu_pkg::alu_rsp_t pop_data,
  output logic              pop_valid,
  input  logic              pop_ready
);

  localparam int DEPTH = `ALU_FIFO_DEPTH;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  alu_pkg::alu_rsp_t mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              pop;

  assign pop_valid = (count != '0);
  assign pop       = pop_valid && pop_ready;
  assign pop_data  = mem[rd_ptr];
  assign full      = (count == CW'(DEPTH)) && !pop;  // A pop this cycle frees a slot.

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Push with pop keeps the count.
      endcase
    end
  end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  alu_pkg::alu_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  output alu_pkg::alu_rsp_t rsp,
  output logic              rsp_valid,
  input  logic              rsp_ready
);

  alu_pkg::alu_rsp_t exec_rsp;
  logic              fifo_full;

  assign req_ready = ~fifo_full;

  // Each accepted request pushes its response in the same cycle.
  alu_exec u_exec (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .accept (req_valid && req_ready),
    .rsp    (exec_rsp)
  );

  result_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_data (exec_rsp),
    .push      (req_valid && !fifo_full),
    .full      (fifo_full),
    .pop_data  (rsp),
    .pop_valid (rsp_valid),
    .pop_ready (rsp_ready)
  );

endmodule

// File: bench/alu_checker.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_checker (
  input  logic              clk,
  input  logic              arst_n,
  input  alu_pkg::alu_req_t req,
  input  logic              req_valid,
  input  logic              req_ready,
  input  alu_pkg::alu_rsp_t rsp,
  input  logic              rsp_valid,
  input  logic              rsp_ready,
  output int                checked,
  output int                errors,
  output int                pending
);

  alu_pkg::flags_t   f_model;  // Model of the F register.
  alu_pkg::alu_rsp_t exp_q[$];

  assign pending = exp_q.size();

  // Z80 arithmetic worked out on plain integers, by width.
  function automatic alu_pkg::alu_rsp_t expect_rsp(alu_pkg::alu_req_t r, alu_pkg::flags_t f);
    alu_pkg::alu_rsp_t e;
    int   bits, full, hmod, a, b, c, res, sa, sb, sres;
    logic is_logic, is_sub;
    e        = '0;
    e.flags  = f;
    is_logic = (r.func == alu_pkg::ALU_AND) || (r.func == alu_pkg::ALU_XOR) ||
               (r.func == alu_pkg::ALU_OR);
    if (is_logic && r.wide) begin
      e.illegal = 1'b1;
      return e;
    end
    bits = r.wide ? 16 : 8;
    full = 1 << bits;
    hmod = r.wide ? 4096 : 16;
    a    = r.wide ? int'(r.x) : int'(r.x[7:0]);
    b    = r.wide ? int'(r.y) : int'(r.y[7:0]);
    if (is_logic) begin
      case (r.func)
        alu_pkg::ALU_AND: res = a & b;
        alu_pkg::ALU_XOR: res = a ^ b;
        default:          res = a | b;
      endcase
      e.flags[`FLAG_H] = (r.func == alu_pkg::ALU_AND);
      e.flags[`FLAG_V] = ~^res[7:0];  // Even parity.
      e.flags[`FLAG_N] = 1'b0;
      e.flags[`FLAG_C] = 1'b0;
    end else begin
      is_sub = (r.func == alu_pkg::ALU_SUB) || (r.func == alu_pkg::ALU_SBC) ||
               (r.func == alu_pkg::ALU_CP);
      c  = ((r.func == alu_pkg::ALU_ADC) || (r.func == alu_pkg::ALU_SBC)) ? int'(f[`FLAG_C]) : 0;
      sa = (a >= full / 2) ? a - full : a;
      sb = (b >= full / 2) ? b - full : b;
      if (is_sub) begin
        res              = a - b - c;
        sres             = sa - sb - c;
        e.flags[`FLAG_H] = (a % hmod) < (b % hmod + c);
        e.flags[`FLAG_C] = (res < 0);
        if (res < 0) res = res + full;
      end else begin
        res              = a + b + c;
        sres             = sa + sb + c;
        e.flags[`FLAG_H] = (a % hmod + b % hmod + c) >= hmod;
        e.flags[`FLAG_C] = (res >= full);
        res              = res % full;
      end
      e.flags[`FLAG_V] = (sres >= full / 2) || (sres < -(full / 2));
      e.flags[`FLAG_N] = is_sub;
    end
    e.result         = res[15:0];
    e.flags[`FLAG_S] = ((res >> (bits - 1)) & 1) != 0;
    e.flags[`FLAG_Z] = (res == 0);
    e.wb             = (r.func != alu_pkg::ALU_CP);
    return e;
  endfunction

  always @(posedge clk or negedge arst_n) begin
    alu_pkg::alu_rsp_t e;
    alu_pkg::alu_rsp_t got;
    if (!arst_n) begin
      f_model = '0;
      exp_q.delete();
    end else begin
      if (rsp_valid && rsp_ready) begin
        got = rsp;
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: a response came out while none was expected", $time);
          errors = errors + 1;
        end else begin
          e = exp_q.pop_front();
          checked = checked + 1;
          if (got !== e) begin
            $display("FAILED at %0t: result %h/%h flags %b/%b illegal %b/%b wb %b/%b (exp/got)",
                     $time, e.result, got.result, e.flags, got.flags,
                     e.illegal, got.illegal, e.wb, got.wb);
            errors = errors + 1;
          end
        end
      end
      if (req_valid && req_ready) begin
        e = expect_rsp(req, f_model);
        exp_q.push_back(e);
        if (!e.illegal) f_model = e.flags;
      end
    end
  end

  initial begin
    checked = 0;
    errors  = 0;
  end

endmodule

// File: bench/alu_assertions.sv
`timescale 1ns/10ps

module alu_assertions (
  input logic              clk,
  input logic              arst_n,
  input alu_pkg::alu_req_t req,
  input logic              req_valid,
  input logic              req_ready,
  input alu_pkg::alu_rsp_t rsp,
  input logic              rsp_valid,
  input logic              rsp_ready
);

  // Nothing is offered while the FIFO is held in reset.
  rsp_low_in_reset: assert property (@(posedge clk) !arst_n |-> !rsp_valid)
    else $error("rsp_valid is high during reset");

  req_held: assert property (@(posedge clk) disable iff (!arst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else $error("request changed or dropped before it was accepted");

  rsp_held: assert property (@(posedge clk) disable iff (!arst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed or dropped before it was taken");

endmodule

bind alu_unit alu_assertions u_assertions (
  .clk       (clk),
  .arst_n    (arst_n),
  .req       (req),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .rsp       (rsp),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready)
);

// File: bench/alu_unit_tb.sv
`timescale 1ns/10ps
`include "alu_cfg.svh"

module alu_unit_tb;

  localparam int TIMEOUT = 200;

  logic              clk;
  logic              arst_n;
  alu_pkg::alu_req_t req;
  logic              req_valid;
  logic              req_ready;
  alu_pkg::alu_rsp_t rsp;
  logic              rsp_valid;
  logic              rsp_ready;
  int                seed;
  int                rdy_mode;  // 0 random, 1 held low, 2 held high.
  logic              rdy_roll;  // Drawn at the falling edge, used at the next rising edge.
  int                tb_errors;
  int                checked, chk_errors, pending;

  alu_unit DUT (
    .clk(clk), .arst_n(arst_n), .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
  );

  alu_checker u_checker (
    .clk(clk), .arst_n(arst_n), .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
    .checked(checked), .errors(chk_errors), .pending(pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    rdy_roll <= ($unsigned($random(seed)) % 10) < 7;
  end

  always @(posedge clk) begin
    if (rdy_mode == 0) rsp_ready <= rdy_roll;
    else               rsp_ready <= (rdy_mode == 2);
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $finish;
  endtask

  function automatic alu_pkg::alu_req_t make_req(input int f, input logic wide,
                                                  input int x, input int y);
    alu_pkg::alu_req_t r;
    r.func = alu_pkg::alu_func_t'(f[3:0]);
    r.wide = wide;
    r.x    = x[15:0];
    r.y    = y[15:0];
    return r;
  endfunction

  // Holds the request until it is taken, then drops valid.
  task automatic send_req(input alu_pkg::alu_req_t r);
    logic got;
    req       <= r;
    req_valid <= 1'b1;
    for (int t = 0; t <= TIMEOUT; t++) begin
      if (t == TIMEOUT) abort_run("Timeout: a request was never accepted.");
      @(negedge clk);
      got = req_ready;
      @(posedge clk);
      if (got) break;
    end
    req_valid <= 1'b0;
  endtask

  task automatic drain;
    for (int t = 0; t <= TIMEOUT; t++) begin
      if (t == TIMEOUT) abort_run("Timeout: expected responses never came out.");
      @(negedge clk);
      if (pending == 0 && !rsp_valid) break;
    end
    @(posedge clk);
  endtask

  task automatic random_reqs(input int n, input int first, input int span, input logic wide);
    for (int i = 0; i < n; i++) begin
      send_req(make_req(first + $unsigned($random(seed)) % span, wide, $random(seed),
                        $random(seed)));
    end
    drain();
  endtask

  task automatic report(input string name);
    $display("%s done: %0d responses checked, %0d errors so far", name, checked,
             chk_errors + tb_errors);
  endtask

  initial begin
    int  acc;
    logic got;
    seed      = 32'h6a2a_c25c;
    rdy_mode  = 0;
    rdy_roll  = 1'b0;
    tb_errors = 0;
    arst_n    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    random_reqs(300, 0, 4, 1'b0);  // ADD to SBC.
    random_reqs(60, 7, 1, 1'b0);   // CP.
    report("test 1 8-bit arithmetic");
    random_reqs(200, 4, 3, 1'b0);
    report("test 2 8-bit logic");
    random_reqs(240, 0, 4, 1'b1);
    random_reqs(60, 7, 1, 1'b1);
    report("test 3 16-bit arithmetic");

    for (int run = 0; run < 4; run++) begin
      send_req(make_req(alu_pkg::ALU_ADD, 1'b0, 'hFF, 1));
      send_req(make_req(alu_pkg::ALU_ADC, 1'b0, 0, 0));
      send_req(make_req(alu_pkg::ALU_SUB, 1'b0, 0, 1));
      send_req(make_req(alu_pkg::ALU_SBC, 1'b0, 0, 0));
      send_req(make_req(alu_pkg::ALU_ADC, 1'b1, 'hFFFF, run));
      send_req(make_req(alu_pkg::ALU_SBC, 1'b1, 0, $random(seed)));
      send_req(make_req(alu_pkg::ALU_AND + run % 3, 1'b1, $random(seed), $random(seed)));
      send_req(make_req(alu_pkg::ALU_ADC, 1'b0, $random(seed), $random(seed)));
    end
    drain();
    report("test 4 carry chaining");

    rdy_mode <= 1;
    repeat (2) @(posedge clk);
    acc = 0;
    req       <= make_req(alu_pkg::ALU_ADD, 1'b0, $random(seed), $random(seed));
    req_valid <= 1'b1;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      got = req_ready;
      @(posedge clk);
      if (got) begin
        acc = acc + 1;
        req <= make_req($unsigned($random(seed)) % 4, 1'b0, $random(seed), $random(seed));
      end
    end
    @(negedge clk);
    if (acc != `ALU_FIFO_DEPTH || req_ready) begin
      $display("FAILED at %0t: %0d requests were accepted under back-pressure, req_ready is %b",
               $time, acc, req_ready);
      tb_errors = tb_errors + 1;
    end
    @(posedge clk);
    rdy_mode <= 2;
    for (int t = 0; t <= TIMEOUT; t++) begin
      if (t == TIMEOUT) abort_run("Timeout: a stalled request was never accepted.");
      @(negedge clk);
      got = req_ready;
      @(posedge clk);
      if (got) break;
    end
    req_valid <= 1'b0;
    drain();
    rdy_mode <= 0;
    report("test 5 back-pressure");

    rdy_mode <= 1;
    send_req(make_req(alu_pkg::ALU_ADD, 1'b1, $random(seed), $random(seed)));
    send_req(make_req(alu_pkg::ALU_SUB, 1'b0, 0, 1));  // Leaves C set.
    arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (rsp_valid || !req_ready) begin
      $display("FAILED at %0t: after reset rsp_valid is %b and req_ready is %b",
               $time, rsp_valid, req_ready);
      tb_errors = tb_errors + 1;
    end
    @(posedge clk);
    rdy_mode <= 0;
    send_req(make_req(alu_pkg::ALU_ADC, 1'b0, 'h10, 'h20));
    drain();
    report("test 6 reset state");

    $display("6 tests, %0d responses checked, %0d errors", checked, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu8.sv
verilog/alu16.sv
verilog/alu_exec.sv
verilog/result_fifo.sv
verilog/alu_unit.sv
bench/alu_checker.sv
bench/alu_assertions.sv
bench/alu_unit_tb.sv

// File: Makefile
TOP = alu_unit_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

obj_dir/V$(TOP): sim.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed."; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "Simulation ended without a result."; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
